// File: list.f
source/cpu_pkg.sv
source/alu.sv
source/register_file.sv
source/flag_unit.sv
source/cpu_sequencer.sv
source/cpu_top.sv
sim/cpu_checker.sv
sim/tb_cpu.sv

// File: Makefile
# Verilator build and run for the cpu testbench

VERILATOR  ?= verilator
TOP        ?= tb_cpu
FILELIST   ?= list.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_TEXT  ?= TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: sim/tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu;
    import cpu_pkg::*;

    localparam word_t result_base  = 32'h0000_4000;
    localparam int    result_first = 'h2000;  // result area in half-words
    localparam int    result_words = 512;
    localparam int    prog_index   = 'h0800;  // reset_pc 0x1000
    localparam int    run_limit    = 5000;
    localparam half_t halt_word    = 16'hffff;  // mode 7 is undecoded

    logic   clk;
    logic   rst_n;
    word_t  addrbus;
    half_t  data_in;
    half_t  data_out;
    logic   write_out;
    flags_t ccr;
    logic   fault;

    half_t mem [65536];
    half_t shadow [65536];  // memory image at program load
    half_t prog [$];

    cpu_top #(.reset_pc(32'h0000_1000), .bus_wait(3)) i_dut (
        .clk(clk), .rst_n(rst_n), .addrbus(addrbus), .data_in(data_in),
        .data_out(data_out), .write_out(write_out), .ccr(ccr), .fault(fault)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    assign data_in = mem[addrbus[16:1]];

    always @(posedge clk) begin
        if (write_out)
            mem[addrbus[16:1]] <= data_out;
    end

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        assert (got === exp) else
            stop_on_error($sformatf("mismatch %s: got %08h, expected %08h", name, got, exp));
    endtask

    function automatic half_t fill_word(input int idx);
        return half_t'(idx * 40503 + 23130);
    endfunction

    function automatic half_t half_at(input word_t addr);
        return mem[addr[16:1]];
    endfunction

    function automatic word_t long_at(input word_t addr);
        return {mem[addr[16:1]], mem[addr[16:1] + 16'd1]};  // big-endian
    endfunction

    function automatic word_t result_at(input int slot);
        return long_at(result_base + word_t'(slot * 4));
    endfunction

    function automatic word_t loaded_result(input int slot);
        logic [15:0] idx;
        idx = 16'(result_first + slot * 2);
        return {shadow[idx], shadow[idx + 16'd1]};
    endfunction

    function automatic half_t op_word(input mode_t mode, input logic [7:0] op,
                                      input reg_addr_t ra);
        return {mode, op, ra};
    endfunction

    task automatic emit_one(input half_t w);
        prog.push_back(w);
    endtask

    task automatic emit_two(input half_t w0, input half_t w1);
        prog.push_back(w0);
        prog.push_back(w1);
    endtask

    task automatic emit_reg_pair(input logic [7:0] op, input reg_addr_t ra,
                                 input reg_addr_t rb, input reg_addr_t rc);
        emit_two(op_word(mode_reg, op, ra), {3'b000, rb, 3'b000, rc});
    endtask

    task automatic emit_imm(input logic [7:0] op, input reg_addr_t ra, input half_t imm);
        emit_two(op_word(mode_imm, op, ra), imm);
    endtask

    task automatic emit_ldi(input reg_addr_t ra, input word_t value);
        emit_two(op_word(mode_imm, op_ldi, ra), value[31:16]);
        emit_one(value[15:0]);
    endtask

    task automatic emit_long(input logic [7:0] op, input reg_addr_t ra,
                             input reg_addr_t base, input int offset);
        logic [10:0] off;
        off = offset[10:0];
        emit_two(op_word(mode_regind, op, ra), {base, off});
    endtask

    task automatic store_result(input reg_addr_t ra, input int slot);
        emit_long(op_stl, ra, 5'd31, slot * 4);
    endtask

    task automatic begin_program;
        prog.delete();
        emit_imm(op_lds, 5'd31, result_base[15:0]);  // r31 points at results
    endtask

    task automatic load_program;
        half_t v;
        for (int i = 0; i < 65536; i++) begin
            v = fill_word(i);
            if (i >= prog_index && i - prog_index < prog.size())
                v = prog[i - prog_index];
            mem[16'(i)] <= v;
            shadow[16'(i)] = v;
        end
    endtask

    task automatic pulse_reset;
        @(posedge clk);
        #1 rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
    endtask

    task automatic wait_for_fault;
        int cycles;
        cycles = 0;
        while (!fault && cycles < run_limit) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        assert (fault) else
            stop_on_error($sformatf("timeout, no fault within %0d cycles", run_limit));
    endtask

    task automatic run_program;
        load_program;
        pulse_reset;
        wait_for_fault;
    endtask

    function automatic word_t model_alu(input alu_func_t func, input word_t a, input word_t b);
        int sh;
        sh = int'(b[4:0]);
        case (func)
            3'd0: return a & b;
            3'd1: return a | b;
            3'd2: return a + b;
            3'd3: return a - b;
            3'd4: return a ^ b;
            3'd5: return a << sh;
            3'd6: return a >> sh;
            default: return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
        endcase
    endfunction

    function automatic flags_t model_cmp_flags(input word_t a, input word_t b);
        longint diff;
        logic   c, n, v, z;
        diff = longint'($signed(a)) - longint'($signed(b));
        c = a < b;  // borrow
        n = diff[31];
        v = diff != longint'($signed(a - b));  // true difference does not fit
        z = a == b;
        return {c, n, v, z};
    endfunction

    function automatic logic model_cond(input cond_t cond, input word_t a, input word_t b);
        case (cond)
            cond_always: return 1'b1;
            cond_eq:     return a == b;
            cond_ne:     return a != b;
            cond_gtu:    return a > b;
            cond_gt:     return $signed(a) > $signed(b);
            cond_ge:     return $signed(a) >= $signed(b);
            cond_le:     return $signed(a) <= $signed(b);
            cond_lt:     return $signed(a) < $signed(b);
            cond_geu:    return a >= b;
            cond_ltu:    return a < b;
            cond_leu:    return a <= b;
            default:     return 1'b0;
        endcase
    endfunction

    task automatic test_reset_state;
        begin_program;
        emit_imm(op_lds, 5'd1, 16'h0001);
        emit_reg_pair(op_cmp, 5'd0, 5'd1, 5'd0);  // 0 - 1 sets carry and negative
        emit_one(halt_word);
        run_program;
        check_word("ccr before reset", word_t'(ccr), word_t'(model_cmp_flags(32'h0, 32'h1)));
        pulse_reset;
        check_word("write_out", word_t'(write_out), 32'h0);
        check_word("fault", word_t'(fault), 32'h0);
        check_word("ccr", word_t'(ccr), 32'h0);
        check_word("addrbus", addrbus, 32'h0000_1000);
        wait_for_fault;
    endtask

    task automatic test_alu_ops;
        word_t a, b;
        half_t imm;
        word_t exp [$];
        begin_program;
        for (int f = 0; f < 8; f++) begin
            a = word_t'($urandom);
            b = word_t'($urandom);
            emit_ldi(5'd1, a);
            emit_ldi(5'd2, b);
            emit_reg_pair({5'b00000, f[2:0]}, 5'd3, 5'd1, 5'd2);  // r3 = r1 op r2
            store_result(5'd3, f);
            exp.push_back(model_alu(f[2:0], a, b));
        end
        for (int f = 0; f < 8; f++) begin
            a = word_t'($urandom);
            imm = half_t'($urandom);
            emit_ldi(5'd4, a);
            emit_imm({5'b00010, f[2:0]}, 5'd4, imm);
            store_result(5'd4, 8 + f);
            exp.push_back(model_alu(f[2:0], a, {{16{imm[15]}}, imm}));
        end
        imm = half_t'($urandom);
        emit_imm(op_lds, 5'd5, imm);
        store_result(5'd5, 16);
        exp.push_back({{16{imm[15]}}, imm});
        emit_one(halt_word);
        run_program;
        for (int k = 0; k < exp.size(); k++)
            check_word($sformatf("alu result slot %0d", k), result_at(k), exp[k]);
    endtask

    task automatic test_move_ops;
        word_t a, b;
        a = word_t'($urandom);
        b = word_t'($urandom);
        begin_program;
        emit_ldi(5'd1, a);
        emit_reg_pair(op_mov, 5'd2, 5'd1, 5'd0);
        store_result(5'd2, 0);
        emit_reg_pair(op_neg, 5'd3, 5'd1, 5'd0);
        store_result(5'd3, 1);
        emit_one(op_word(mode_reg, op_inc, 5'd1));
        store_result(5'd1, 2);
        emit_ldi(5'd4, b);
        emit_one(op_word(mode_reg, op_dec, 5'd4));
        store_result(5'd4, 3);
        emit_ldi(5'd6, 32'hffff_ffff);
        emit_one(op_word(mode_reg, op_inc, 5'd6));  // wraps to zero
        store_result(5'd6, 4);
        emit_imm(op_lds, 5'd7, 16'h0000);
        emit_one(op_word(mode_reg, op_dec, 5'd7));
        store_result(5'd7, 5);
        emit_one(halt_word);
        run_program;
        check_word("mov result", result_at(0), a);
        check_word("neg result", result_at(1), 32'h0 - a);
        check_word("inc result", result_at(2), a + 32'd1);
        check_word("dec result", result_at(3), b - 32'd1);
        check_word("inc wrap result", result_at(4), 32'h0);
        check_word("dec wrap result", result_at(5), 32'hffff_ffff);
    endtask

    task automatic test_compare_branch;
        word_t a, b, marker, exp;
        cond_t conds [$];
        conds = '{cond_always, cond_eq, cond_ne, cond_gtu, cond_gt, cond_ge,
                  cond_le, cond_lt, cond_geu, cond_ltu, cond_leu, cond_never};
        for (int p = 0; p < 6; p++) begin
            a = word_t'($urandom);
            b = word_t'($urandom);
            if (p == 0)
                b = a;
            else if (p == 1) begin
                a = 32'h7fff_ffff;  // signed overflow
                b = 32'hffff_ffff;
            end else if (p == 2) begin
                a = 32'h8000_0000;
                b = 32'h0000_0001;
            end
            marker = word_t'($urandom);
            begin_program;
            emit_ldi(5'd1, a);
            emit_ldi(5'd2, b);
            emit_ldi(5'd3, marker);
            emit_reg_pair(op_cmp, 5'd1, 5'd2, 5'd0);
            for (int k = 0; k < conds.size(); k++) begin
                emit_two(op_word(mode_pcind, op_branch_base | {4'h0, conds[k]}, 5'd0), 16'h0004);
                store_result(5'd3, k);  // skipped when taken
            end
            emit_one(halt_word);
            run_program;
            check_word("ccr", word_t'(ccr), word_t'(model_cmp_flags(a, b)));
            for (int k = 0; k < conds.size(); k++) begin
                exp = model_cond(conds[k], a, b) ? loaded_result(k) : marker;
                check_word($sformatf("branch cond %h slot", conds[k]), result_at(k), exp);
            end
        end
    endtask

    task automatic test_long_memory;
        word_t value;
        value = word_t'($urandom);
        begin_program;
        emit_imm(op_lds, 5'd30, 16'h4400);
        emit_ldi(5'd7, value);
        emit_long(op_stl, 5'd7, 5'd30, -16);  // lands at 0x43f0
        emit_long(op_ldl, 5'd8, 5'd30, -16);
        store_result(5'd8, 0);
        emit_one(halt_word);
        run_program;
        check_word("mem[43f0]", word_t'(half_at(32'h0000_43f0)), {16'h0000, value[31:16]});
        check_word("mem[43f2]", word_t'(half_at(32'h0000_43f2)), {16'h0000, value[15:0]});
        check_word("ld.l result", result_at(0), value);
    endtask

    task automatic test_fault;
        begin_program;
        emit_imm(op_lds, 5'd9, 16'h1234);
        emit_one(op_word(mode_inh, op_nop, 5'd0));
        store_result(5'd9, 0);
        emit_one(op_word(mode_inh, 8'h01, 5'd0));  // no such opcode
        run_program;
        check_word("lds result", result_at(0), 32'h0000_1234);
        repeat (8) begin
            @(posedge clk);
            #1;
            assert (fault && !write_out) else
                stop_on_error("fault did not stay high with write_out low");
        end
        for (int i = 0; i < 65536; i++) begin
            if (i < result_first || i >= result_first + result_words)
                assert (mem[16'(i)] === shadow[16'(i)]) else
                    stop_on_error($sformatf("mismatch mem[%04h]: got %04h, expected %04h",
                                            i, mem[16'(i)], shadow[16'(i)]));
        end
    endtask

    initial begin
        rst_n = 1'b0;
        void'($urandom(32'h926fa2e5));
        test_reset_state;
        test_alu_ops;
        test_move_ops;
        test_compare_branch;
        test_long_memory;
        test_fault;
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: sim/cpu_checker.sv
`timescale 1ns/1ps

module cpu_checker (
    input logic           clk,
    input logic           rst_n,
    input cpu_pkg::word_t addrbus,
    input logic           write_out,
    input logic           fault
);

    a_single_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        write_out |=> !write_out)
        else $error("write_out high on two consecutive cycles");

    a_even_address: assert property (@(posedge clk) disable iff (!rst_n)
        write_out |-> !addrbus[0])
        else $error("odd addrbus %08h during a write strobe", addrbus);

    a_fault_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        fault |=> fault)
        else $error("fault dropped without reset");

    a_fault_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        fault |-> !write_out)
        else $error("write_out high while in fault");

endmodule

bind cpu_top cpu_checker i_checker (
    .clk(clk), .rst_n(rst_n), .addrbus(addrbus),
    .write_out(write_out), .fault(fault)
);

// File: source/cpu_top.sv
`timescale 1ns/1ps

module cpu_top #(
    parameter cpu_pkg::word_t reset_pc = 32'hffc0_0000,
    parameter int             bus_wait = 3
) (
    input  logic              clk,
    input  logic              rst_n,
    output cpu_pkg::word_t    addrbus,
    input  cpu_pkg::half_t    data_in,
    output cpu_pkg::half_t    data_out,
    output logic              write_out,
    output cpu_pkg::flags_t   ccr,
    output logic              fault
);
    import cpu_pkg::*;

    reg_addr_t rd_addr1, rd_addr2, wr_addr;
    word_t     rd_data1, rd_data2, wr_data;
    half_en_t  wr_half_en;
    word_t     alu_in1, alu_in2, alu_result;
    alu_func_t alu_op;
    flags_t    alu_flags;
    logic      flag_update, taken;
    cond_t     cond;

    cpu_sequencer #(.reset_pc(reset_pc), .bus_wait(bus_wait)) i_sequencer (
        .clk(clk), .rst_n(rst_n),
        .addrbus(addrbus), .data_in(data_in), .data_out(data_out),
        .write_out(write_out), .fault(fault),
        .rd_addr1(rd_addr1), .rd_addr2(rd_addr2),
        .rd_data1(rd_data1), .rd_data2(rd_data2),
        .wr_addr(wr_addr), .wr_data(wr_data), .wr_half_en(wr_half_en),
        .alu_in1(alu_in1), .alu_in2(alu_in2), .alu_op(alu_op), .alu_result(alu_result),
        .flag_update(flag_update), .cond(cond), .taken(taken)
    );

    register_file i_regs (
        .clk(clk), .rst_n(rst_n),
        .rd_addr1(rd_addr1), .rd_addr2(rd_addr2),
        .rd_data1(rd_data1), .rd_data2(rd_data2),
        .wr_addr(wr_addr), .wr_data(wr_data), .wr_half_en(wr_half_en)
    );

    alu i_alu (
        .in1(alu_in1), .in2(alu_in2), .func(alu_op),
        .result(alu_result), .flags(alu_flags)
    );

    flag_unit i_flags (
        .clk(clk), .rst_n(rst_n),
        .alu_flags(alu_flags), .update(flag_update), .cond(cond),
        .ccr(ccr), .taken(taken)
    );

endmodule

// File: source/cpu_sequencer.sv
`timescale 1ns/1ps

module cpu_sequencer #(
    parameter cpu_pkg::word_t reset_pc = 32'hffc0_0000,
    parameter int             bus_wait = 3
) (
    input  logic                 clk,
    input  logic                 rst_n,
    output cpu_pkg::word_t       addrbus,
    input  cpu_pkg::half_t       data_in,
    output cpu_pkg::half_t       data_out,
    output logic                 write_out,
    output logic                 fault,
    output cpu_pkg::reg_addr_t   rd_addr1,
    output cpu_pkg::reg_addr_t   rd_addr2,
    input  cpu_pkg::word_t       rd_data1,
    input  cpu_pkg::word_t       rd_data2,
    output cpu_pkg::reg_addr_t   wr_addr,
    output cpu_pkg::word_t       wr_data,
    output cpu_pkg::half_en_t    wr_half_en,
    output cpu_pkg::word_t       alu_in1,
    output cpu_pkg::word_t       alu_in2,
    output cpu_pkg::alu_func_t   alu_op,
    input  cpu_pkg::word_t       alu_result,
    output logic                 flag_update,
    output cpu_pkg::cond_t       cond,
    input  logic                 taken
);
    import cpu_pkg::*;

    localparam logic [3:0] st_fetch1 = 4'h0, st_fetch2 = 4'h1, st_fetch3 = 4'h2;
    localparam logic [3:0] st_eval1  = 4'h3, st_eval2  = 4'h4, st_eval3  = 4'h5;
    localparam logic [3:0] st_store  = 4'h6, st_store2 = 4'h7, st_store3 = 4'h8;
    localparam logic [3:0] st_load   = 4'h9, st_load2  = 4'ha, st_load3  = 4'hb;
    localparam logic [3:0] st_load4  = 4'hc, st_fault  = 4'hd;

    localparam logic sel_pc  = 1'b0, sel_mar = 1'b1;
    localparam logic half_hi = 1'b0, half_lo = 1'b1;
    localparam int   cnt_w   = (bus_wait > 0) ? $clog2(bus_wait + 1) : 1;

    logic [3:0]       state, state_next;
    word_t            pc, pc_next, mar, mar_next, mdr, mdr_next;
    half_t            ir, ir_next;
    logic             addr_sel, addr_sel_next;
    logic             half_sel, half_sel_next;
    logic             write_next;
    logic [cnt_w-1:0] wait_cnt, wait_next;

    mode_t      ir_mode;
    logic [7:0] ir_op;
    reg_addr_t  ir_ra;
    ext_word_u  ext;
    word_t      simm, offset;
    logic       is_branch;

    assign ir_mode = ir[15:13];
    assign ir_op   = ir[12:5];
    assign ir_ra   = ir[4:0];
    assign ext     = mdr[15:0];  // extension word
    assign simm    = {{16{mdr[15]}}, mdr[15:0]};
    assign offset  = {{21{ext.ind.offset[10]}}, ext.ind.offset};

    assign is_branch = (ir_op[7:4] == op_branch_base[7:4]) && (cond != 4'hb)
                       && (cond <= cond_never);

    assign addrbus  = addr_sel ? mar : pc;
    assign data_out = half_sel ? mdr[15:0] : mdr[31:16];
    assign cond     = ir_op[3:0];
    assign fault    = (state == st_fault);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= st_fetch1;
            pc        <= reset_pc;
            addr_sel  <= sel_pc;
            half_sel  <= half_hi;
            wait_cnt  <= '0;
            write_out <= 1'b0;
        end else begin
            state     <= state_next;
            pc        <= pc_next;
            addr_sel  <= addr_sel_next;
            half_sel  <= half_sel_next;
            wait_cnt  <= wait_next;
            write_out <= write_next;
        end
    end

    always_ff @(posedge clk) begin
        ir  <= ir_next;
        mar <= mar_next;
        mdr <= mdr_next;
    end

    always_comb begin
        state_next    = state;
        pc_next       = pc;
        ir_next       = ir;
        mar_next      = mar;
        mdr_next      = mdr;
        addr_sel_next = addr_sel;
        half_sel_next = half_sel;
        wait_next     = wait_cnt;
        write_next    = 1'b0;  // strobe lasts one cycle
        rd_addr1      = ir_ra;
        rd_addr2      = ext.pair.rb;
        wr_addr       = ir_ra;
        wr_data       = alu_result;
        wr_half_en    = half_none;
        alu_in1       = rd_data1;
        alu_in2       = rd_data2;
        alu_op        = alu_add;
        flag_update   = 1'b0;
        case (state)
            st_fetch1, st_fetch2, st_fetch3: begin
                if (wait_cnt == cnt_w'(bus_wait)) begin
                    wait_next = '0;
                    pc_next   = pc + 32'd2;
                    case (state)
                        st_fetch1: begin
                            ir_next    = data_in;
                            state_next = st_eval1;
                        end
                        st_fetch2: begin
                            mdr_next   = {16'h0000, data_in};
                            state_next = st_eval2;
                        end
                        default: begin
                            mdr_next   = {mdr[15:0], data_in};  // ldi low half
                            state_next = st_eval3;
                        end
                    endcase
                end else begin
                    wait_next = wait_cnt + 1'b1;
                end
            end
            st_eval1: begin
                case ({ir_mode, ir_op})
                    {mode_inh, op_nop}: state_next = st_fetch1;
                    {mode_reg, op_inc}: begin
                        alu_in2    = 32'd1;
                        wr_half_en = half_both;
                        state_next = st_fetch1;
                    end
                    {mode_reg, op_dec}: begin
                        alu_op     = alu_sub;
                        alu_in2    = 32'd1;
                        wr_half_en = half_both;
                        state_next = st_fetch1;
                    end
                    default: state_next = st_fetch2;
                endcase
            end
            st_eval2: begin
                state_next = st_fetch1;
                if (ir_mode == mode_reg && ir_op[7:3] == 5'b00000) begin  // rA = rB op rC
                    rd_addr1   = ext.pair.rb;
                    rd_addr2   = ext.pair.rc;
                    alu_op     = ir_op[2:0];
                    wr_half_en = half_both;
                end else if (ir_mode == mode_imm && ir_op[7:3] == 5'b00010) begin
                    alu_op     = ir_op[2:0];
                    alu_in2    = simm;
                    wr_half_en = half_both;
                end else begin
                    case ({ir_mode, ir_op})
                        {mode_imm, op_ldi}: state_next = st_fetch3;
                        {mode_imm, op_lds}: begin
                            wr_data    = simm;
                            wr_half_en = half_both;
                        end
                        {mode_reg, op_mov}: begin
                            rd_addr1   = ext.pair.rb;
                            wr_data    = rd_data1;
                            wr_half_en = half_both;
                        end
                        {mode_reg, op_cmp}: begin
                            alu_op      = alu_sub;
                            flag_update = 1'b1;
                        end
                        {mode_reg, op_neg}: begin
                            alu_op     = alu_sub;
                            alu_in1    = '0;
                            wr_half_en = half_both;
                        end
                        {mode_regind, op_stl}: begin
                            rd_addr1      = ext.ind.base;
                            rd_addr2      = ir_ra;
                            alu_in2       = offset;
                            mar_next      = alu_result;
                            mdr_next      = rd_data2;
                            addr_sel_next = sel_mar;
                            half_sel_next = half_hi;  // high half goes first
                            write_next    = 1'b1;
                            state_next    = st_store;
                        end
                        {mode_regind, op_ldl}: begin
                            rd_addr1      = ext.ind.base;
                            alu_in2       = offset;
                            mar_next      = alu_result;
                            addr_sel_next = sel_mar;
                            state_next    = st_load;
                        end
                        default: begin
                            if (ir_mode == mode_pcind && is_branch) begin
                                if (taken)
                                    pc_next = pc + simm;  // pc already past ext word
                            end else begin
                                state_next = st_fault;
                            end
                        end
                    endcase
                end
            end
            st_eval3: begin
                wr_data    = mdr;  // ldi
                wr_half_en = half_both;
                state_next = st_fetch1;
            end
            st_store: state_next = st_store2;
            st_store2: begin
                mar_next      = mar + 32'd2;
                half_sel_next = half_lo;
                write_next    = 1'b1;
                state_next    = st_store3;
            end
            st_store3: begin
                addr_sel_next = sel_pc;
                state_next    = st_fetch1;
            end
            st_load: state_next = st_load2;
            st_load2: begin
                wr_data    = {data_in, 16'h0000};
                wr_half_en = half_high;
                mar_next   = mar + 32'd2;
                state_next = st_load3;
            end
            st_load3: state_next = st_load4;
            st_load4: begin
                wr_data       = {16'h0000, data_in};
                wr_half_en    = half_low;
                addr_sel_next = sel_pc;
                state_next    = st_fetch1;
            end
            default: state_next = st_fault;  // fault is a dead end
        endcase
    end

endmodule

// File: source/flag_unit.sv
`timescale 1ns/1ps

module flag_unit (
    input  logic              clk,
    input  logic              rst_n,
    input  cpu_pkg::flags_t   alu_flags,
    input  logic              update,
    input  cpu_pkg::cond_t    cond,
    output cpu_pkg::flags_t   ccr,
    output logic              taken
);
    import cpu_pkg::*;

    logic c, n, v, z;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            ccr <= '0;
        else if (update)
            ccr <= alu_flags;  // cmp only
    end

    assign {c, n, v, z} = ccr;

    always_comb begin
        case (cond)
            cond_always: taken = 1'b1;
            cond_eq:     taken = z;
            cond_ne:     taken = !z;
            cond_gtu:    taken = !(z | c);
            cond_gt:     taken = !(z | (n ^ v));
            cond_ge:     taken = !(n ^ v);
            cond_le:     taken = z | (n ^ v);
            cond_lt:     taken = n ^ v;
            cond_geu:    taken = !c;
            cond_ltu:    taken = c;
            cond_leu:    taken = c | z;
            cond_never:  taken = 1'b0;
            default:     taken = 1'b0;
        endcase
    end

endmodule

// File: source/register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic                clk,
    input  logic                rst_n,
    input  cpu_pkg::reg_addr_t  rd_addr1,
    input  cpu_pkg::reg_addr_t  rd_addr2,
    output cpu_pkg::word_t      rd_data1,
    output cpu_pkg::word_t      rd_data2,
    input  cpu_pkg::reg_addr_t  wr_addr,
    input  cpu_pkg::word_t      wr_data,
    input  cpu_pkg::half_en_t   wr_half_en
);
    import cpu_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else begin
            if (wr_half_en[1])
                regs[wr_addr][31:16] <= wr_data[31:16];
            if (wr_half_en[0])
                regs[wr_addr][15:0] <= wr_data[15:0];
        end
    end

    // combinational read ports
    assign rd_data1 = regs[rd_addr1];
    assign rd_data2 = regs[rd_addr2];

endmodule

// File: source/alu.sv
`timescale 1ns/1ps

module alu (
    input  cpu_pkg::word_t     in1,
    input  cpu_pkg::word_t     in2,
    input  cpu_pkg::alu_func_t func,
    output cpu_pkg::word_t     result,
    output cpu_pkg::flags_t    flags
);
    import cpu_pkg::*;

    logic [32:0] sum;
    logic        carry;
    logic        overflow;

    always_comb begin
        sum      = '0;
        carry    = 1'b0;
        overflow = 1'b0;
        result   = '0;
        case (func)
            alu_and: result = in1 & in2;
            alu_or:  result = in1 | in2;
            alu_add: begin
                sum      = {1'b0, in1} + {1'b0, in2};
                result   = sum[31:0];
                carry    = sum[32];
                overflow = (in1[31] == in2[31]) && (result[31] != in1[31]);
            end
            alu_sub: begin
                sum      = {1'b0, in1} - {1'b0, in2};
                result   = sum[31:0];
                carry    = sum[32];  // borrow
                overflow = (in1[31] != in2[31]) && (result[31] != in1[31]);
            end
            alu_xor: result = in1 ^ in2;
            alu_shl: result = in1 << in2[4:0];
            alu_shr: result = in1 >> in2[4:0];
            alu_sra: result = word_t'($signed(in1) >>> in2[4:0]);
            default: result = '0;
        endcase
    end

    assign flags = {carry, result[31], overflow, (result == '0)};

endmodule

// File: source/cpu_pkg.sv
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [15:0] half_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [2:0]  mode_t;
    typedef logic [2:0]  alu_func_t;
    typedef logic [3:0]  cond_t;
    typedef logic [3:0]  flags_t;    // {carry, negative, overflow, zero}
    typedef logic [1:0]  half_en_t;  // {high, low}

    localparam mode_t mode_inh    = 3'd0;
    localparam mode_t mode_imm    = 3'd1;
    localparam mode_t mode_regind = 3'd2;
    localparam mode_t mode_reg    = 3'd3;
    localparam mode_t mode_pcind  = 3'd5;

    localparam alu_func_t alu_and = 3'd0;
    localparam alu_func_t alu_or  = 3'd1;
    localparam alu_func_t alu_add = 3'd2;
    localparam alu_func_t alu_sub = 3'd3;
    localparam alu_func_t alu_xor = 3'd4;
    localparam alu_func_t alu_shl = 3'd5;
    localparam alu_func_t alu_shr = 3'd6;
    localparam alu_func_t alu_sra = 3'd7;

    localparam cond_t cond_always = 4'h0;
    localparam cond_t cond_eq     = 4'h1;
    localparam cond_t cond_ne     = 4'h2;
    localparam cond_t cond_gtu    = 4'h3;
    localparam cond_t cond_gt     = 4'h4;
    localparam cond_t cond_ge     = 4'h5;
    localparam cond_t cond_le     = 4'h6;
    localparam cond_t cond_lt     = 4'h7;
    localparam cond_t cond_geu    = 4'h8;
    localparam cond_t cond_ltu    = 4'h9;
    localparam cond_t cond_leu    = 4'ha;
    localparam cond_t cond_never  = 4'hc;

    localparam half_en_t half_none = 2'b00;
    localparam half_en_t half_low  = 2'b01;
    localparam half_en_t half_high = 2'b10;
    localparam half_en_t half_both = 2'b11;

    // opcode meaning depends on the mode field
    localparam logic [7:0] op_nop         = 8'h00;
    localparam logic [7:0] op_mov         = 8'h10;
    localparam logic [7:0] op_cmp         = 8'h11;
    localparam logic [7:0] op_neg         = 8'h12;
    localparam logic [7:0] op_inc         = 8'h13;
    localparam logic [7:0] op_dec         = 8'h14;
    localparam logic [7:0] op_ldi         = 8'h20;
    localparam logic [7:0] op_lds         = 8'h21;
    localparam logic [7:0] op_stl         = 8'h20;
    localparam logic [7:0] op_ldl         = 8'h21;
    localparam logic [7:0] op_branch_base = 8'h20;

    typedef union packed {
        struct packed {
            logic [2:0] pad_hi;
            reg_addr_t  rb;
            logic [2:0] pad_lo;
            reg_addr_t  rc;
        } pair;
        struct packed {
            reg_addr_t   base;
            logic [10:0] offset;  // signed
        } ind;
    } ext_word_u;

endpackage
